/* hdl/hist_pkg.sv */
package hist_pkg;

    localparam int BIN_W          = 4;
    localparam int BIN_NUM        = 16;                   // bins per histogram
    localparam int PIXEL_W        = 2;
    localparam int PIXEL_NUM      = 4;                    // pixels sharing the memory
    localparam int COUNT_W        = 8;
    localparam int COUNT_MAX      = 255;                  // saturation value
    localparam int HITS_PER_PIXEL = 3;
    localparam int ACQ_NUM        = 2;                    // acquisitions per set
    localparam int MEM_DEPTH      = PIXEL_NUM * BIN_NUM;
    localparam int MEM_AW         = PIXEL_W + BIN_W;

    // sequencer counter widths
    localparam int HIT_CNT_W = $clog2(HITS_PER_PIXEL);
    localparam int ACQ_CNT_W = $clog2(ACQ_NUM);

    typedef logic [BIN_W-1:0]     bin_t;
    typedef logic [PIXEL_W-1:0]   pixel_t;
    typedef logic [COUNT_W-1:0]   count_t;
    typedef logic [MEM_AW-1:0]    mem_addr_t;             // {pixel, bin}
    typedef logic [HIT_CNT_W-1:0] hit_cnt_t;
    typedef logic [ACQ_CNT_W-1:0] acq_cnt_t;

    typedef enum logic {
        SEQ_COUNT,                                        // taking hits
        SEQ_CLEAR                                         // waiting on the memory sweep
    } seq_state_t;

    // terminal counter values
    localparam hit_cnt_t HIT_LAST   = hit_cnt_t'(HITS_PER_PIXEL - 1);
    localparam pixel_t   PIXEL_LAST = pixel_t'(PIXEL_NUM - 1);
    localparam acq_cnt_t ACQ_LAST   = acq_cnt_t'(ACQ_NUM - 1);

endpackage

/* hdl/bin_access_if.sv */
interface bin_access_if;
    import hist_pkg::*;

    logic   hit_en;                                       // one update per cycle
    bin_t   bin;
    pixel_t pixel;
    logic   group_last;                                   // final hit of a pixel group
    logic   clear_start;                                  // one-cycle sweep launch
    logic   clear_busy;

    modport seq (
        output hit_en, bin, pixel, group_last, clear_start,
        input  clear_busy
    );

    modport mem (
        input  hit_en, bin, pixel, group_last, clear_start,
        output clear_busy
    );

endinterface

/* hdl/bin_update_if.sv */
interface bin_update_if;
    import hist_pkg::*;

    logic   upd_valid;
    pixel_t upd_pixel;
    bin_t   upd_bin;
    count_t upd_count;                                    // count after the increment
    logic   upd_last;                                     // closes the pixel group

    modport mem (
        output upd_valid, upd_pixel, upd_bin, upd_count, upd_last
    );

    modport peak (
        input  upd_valid, upd_pixel, upd_bin, upd_count, upd_last
    );

endinterface

/* hdl/acq_sequencer.sv */
module acq_sequencer (
    input  logic           clk,
    input  logic           combin_res,
    input  logic           hit,
    input  hist_pkg::bin_t bin,
    bin_access_if.seq      acc,
    output logic           acq_done,
    output logic           hist_sel
);
    import hist_pkg::*;

    seq_state_t state;
    hit_cnt_t   hit_cnt;
    pixel_t     pixel_cnt;
    acq_cnt_t   acq_cnt;
    logic       clear_idle;
    logic       accept;
    logic       group_end;
    logic       pixel_end;
    logic       set_end;

    // sweep neither launched nor running
    assign clear_idle = !acc.clear_busy && !acc.clear_start;

    // the cycle busy falls a hit may already be taken
    assign accept = hit && ((state == SEQ_COUNT) || clear_idle);

    assign group_end = (hit_cnt == HIT_LAST);
    assign pixel_end = group_end && (pixel_cnt == PIXEL_LAST);
    assign set_end   = pixel_end && (acq_cnt == ACQ_LAST);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state           <= SEQ_COUNT;
            hit_cnt         <= '0;
            pixel_cnt       <= '0;
            acq_cnt         <= '0;
            acc.hit_en      <= 1'b0;
            acc.group_last  <= 1'b0;
            acc.clear_start <= 1'b0;
            acq_done        <= 1'b0;
            hist_sel        <= 1'b0;
        end else begin
            acc.hit_en      <= accept;
            acc.group_last  <= accept && group_end;
            acc.clear_start <= accept && set_end;       // sweep starts with the last update
            acq_done        <= acc.clear_start;
            if (acc.clear_start) begin
                hist_sel <= !hist_sel;                   // next set goes to the other histogram
            end

            if (accept) begin
                hit_cnt <= group_end ? '0 : hit_cnt + 1'b1;
                if (group_end) begin
                    pixel_cnt <= pixel_end ? '0 : pixel_cnt + 1'b1;
                end
                if (pixel_end) begin
                    acq_cnt <= set_end ? '0 : acq_cnt + 1'b1;
                end
            end

            case (state)
                SEQ_COUNT: begin
                    if (accept && set_end) begin
                        state <= SEQ_CLEAR;
                    end
                end
                SEQ_CLEAR: begin
                    if (clear_idle) begin
                        state <= SEQ_COUNT;
                    end
                end
                default: state <= SEQ_COUNT;
            endcase
        end
    end

    // bin and pixel of the forwarded hit
    always_ff @(posedge clk) begin
        if (accept) begin
            acc.bin   <= bin;
            acc.pixel <= pixel_cnt;
        end
    end

endmodule

/* hdl/bin_memory.sv */
module bin_memory (
    input  logic      clk,
    input  logic      combin_res,
    bin_access_if.mem acc,
    bin_update_if.mem upd
);
    import hist_pkg::*;

    count_t    mem [MEM_DEPTH];
    mem_addr_t hit_addr;
    mem_addr_t clr_addr;
    count_t    cur_count;
    count_t    next_count;

    assign hit_addr  = {acc.pixel, acc.bin};
    assign cur_count = mem[hit_addr];

    // saturating increment
    assign next_count = (cur_count == count_t'(COUNT_MAX)) ? cur_count : cur_count + 1'b1;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (acc.clear_busy) begin
            mem[clr_addr] <= '0;                         // one word per cycle
        end else if (acc.hit_en) begin
            mem[hit_addr] <= next_count;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            acc.clear_busy <= 1'b0;
            clr_addr       <= '0;
            upd.upd_valid  <= 1'b0;
            upd.upd_last   <= 1'b0;
        end else begin
            upd.upd_valid <= acc.hit_en;
            upd.upd_last  <= acc.hit_en && acc.group_last;

            if (acc.clear_start) begin
                acc.clear_busy <= 1'b1;
                clr_addr       <= '0;
            end else if (acc.clear_busy) begin
                clr_addr <= clr_addr + 1'b1;
                if (clr_addr == mem_addr_t'(MEM_DEPTH - 1)) begin
                    acc.clear_busy <= 1'b0;              // last word written this cycle
                end
            end
        end
    end

    // update payload for the peak tracker and the count output
    always_ff @(posedge clk) begin
        if (acc.hit_en) begin
            upd.upd_pixel <= acc.pixel;
            upd.upd_bin   <= acc.bin;
            upd.upd_count <= next_count;
        end
    end

endmodule

/* hdl/peak_tracker.sv */
module peak_tracker (
    input  logic             clk,
    input  logic             combin_res,
    bin_update_if.peak       upd,
    output logic             peak_valid,
    output hist_pkg::pixel_t peak_pixel,
    output hist_pkg::bin_t   peak_bin,
    output hist_pkg::count_t peak_count
);
    import hist_pkg::*;

    count_t best_count;                                   // zero marks an empty group
    bin_t   best_bin;
    logic   take;
    count_t cand_count;
    bin_t   cand_bin;

    // strictly greater so the first bin to reach the max keeps it
    assign take       = (upd.upd_count > best_count);
    assign cand_count = take ? upd.upd_count : best_count;
    assign cand_bin   = take ? upd.upd_bin : best_bin;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            peak_valid <= 1'b0;
            best_count <= '0;
        end else begin
            peak_valid <= upd.upd_valid && upd.upd_last;
            if (upd.upd_valid) begin
                best_count <= upd.upd_last ? '0 : cand_count;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (upd.upd_valid) begin
            best_bin <= cand_bin;
            if (upd.upd_last) begin
                peak_pixel <= upd.upd_pixel;
                peak_bin   <= cand_bin;                  // includes the closing update
                peak_count <= cand_count;
            end
        end
    end

endmodule

/* hdl/hist_top.sv */
module hist_top (
    input  logic             clk,
    input  logic             combin_res,
    input  logic             hit,
    input  hist_pkg::bin_t   bin,
    output hist_pkg::count_t bin_count,
    output logic             count_valid,
    output logic             peak_valid,
    output hist_pkg::pixel_t peak_pixel,
    output hist_pkg::bin_t   peak_bin,
    output hist_pkg::count_t peak_count,
    output logic             acq_done,
    output logic             hist_sel,
    output logic             busy
);

    bin_access_if u_acc ();                               // sequencer to memory
    bin_update_if u_upd ();                               // memory to peak tracker

    acq_sequencer u_seq (
        .clk        (clk),
        .combin_res (combin_res),
        .hit        (hit),
        .bin        (bin),
        .acc        (u_acc),
        .acq_done   (acq_done),
        .hist_sel   (hist_sel)
    );

    bin_memory u_mem (
        .clk        (clk),
        .combin_res (combin_res),
        .acc        (u_acc),
        .upd        (u_upd)
    );

    peak_tracker u_peak (
        .clk        (clk),
        .combin_res (combin_res),
        .upd        (u_upd),
        .peak_valid (peak_valid),
        .peak_pixel (peak_pixel),
        .peak_bin   (peak_bin),
        .peak_count (peak_count)
    );

    assign busy        = u_acc.clear_busy;                // high for the whole sweep
    assign bin_count   = u_upd.upd_count;
    assign count_valid = u_upd.upd_valid;

endmodule

/* tests/tb_clock.sv */
module tb_clock #(
    parameter int PERIOD = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;                // free running
    end

endmodule

/* tests/hist_tb.sv */
module hist_tb;
    import hist_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int NUM_SETS   = 4;
    localparam int SET_HITS   = HITS_PER_PIXEL * PIXEL_NUM * ACQ_NUM;
    localparam int MAX_GAP    = 3;                        // idle cycles before a hit is forced
    localparam int RUN_CYCLES = NUM_SETS * (SET_HITS * (MAX_GAP + 1) + MEM_DEPTH + 2);
    localparam int WATCHDOG   = 2 * (RUN_CYCLES + MEM_DEPTH + 16) * CLK_PERIOD;
    localparam int T_RESET    = 0;
    localparam int T_COUNT    = 1;
    localparam int T_PEAK     = 2;
    localparam int T_SET      = 3;
    localparam int T_CLEAR    = 4;

    typedef struct packed {
        logic   cv;                                       // count_valid due
        logic   drop;                                     // hit driven while busy
        logic   fresh;                                    // first count of a bin after a clear
        count_t cnt;
        logic   pv;
        pixel_t ppix;
        bin_t   pbin;
        count_t pcnt;
        logic   done;
    } expect_t;

    logic   clk;
    logic   combin_res;
    logic   hit;
    bin_t   bin;
    count_t bin_count;
    logic   count_valid;
    logic   peak_valid;
    pixel_t peak_pixel;
    bin_t   peak_bin;
    count_t peak_count;
    logic   acq_done;
    logic   hist_sel;
    logic   busy;

    count_t      model_mem [MEM_DEPTH];
    expect_t     pipe [4];                                // index is cycles since the drive
    int          hit_idx   = 0;
    int          pix_idx   = 0;
    int          acq_idx   = 0;
    int          sets_done = 0;
    int          accepted  = 0;
    int          gap       = 0;
    int          busy_left = 0;                           // clear cycles still expected
    count_t      best_cnt  = '0;
    bin_t        best_bin  = '0;
    logic        model_sel = 1'b0;
    logic [31:0] rnd       = 32'h1cd4;
    int          checks [5];
    int          errors [5];
    string       names [5] = '{"reset_state", "bin_counts", "peak_reports",
                               "set_completion", "clear_drop"};

    tb_clock #(.PERIOD(CLK_PERIOD)) u_clk (.clk(clk));

    hist_top u_dut (.*);

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input int t, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks[t]++;
        assert (actual === expected) else begin
            errors[t]++;
            $display("FAILED %s: expected %0d, actual %0d", names[t], expected, actual);
        end
    endtask

    task automatic check_pulse(input int t, input string what, input logic expected,
                               input logic actual);
        checks[t]++;
        assert (actual === expected) else begin
            errors[t]++;
            if (expected) begin
                $display("%s: %s pulse missing", names[t], what);
            end else begin
                $display("%s: unexpected %s pulse", names[t], what);
            end
        end
    endtask

    task automatic check_outputs();
        expect_t c;
        expect_t p;
        c = pipe[2];                                      // count and set end stage
        p = pipe[3];                                      // peak stage
        check_pulse(c.drop ? T_CLEAR : T_COUNT, "count_valid", c.cv, count_valid);
        if (c.cv) begin
            check_value(T_COUNT, 32'(c.cnt), 32'(bin_count));
            if (c.fresh) begin
                check_value(T_CLEAR, 32'd1, 32'(bin_count));
            end
        end
        check_pulse(T_PEAK, "peak_valid", p.pv, peak_valid);
        if (p.pv) begin
            check_value(T_PEAK, 32'(p.ppix), 32'(peak_pixel));
            check_value(T_PEAK, 32'(p.pbin), 32'(peak_bin));
            check_value(T_PEAK, 32'(p.pcnt), 32'(peak_count));
        end
        check_pulse(T_SET, "acq_done", c.done, acq_done);
        if (c.done) begin
            model_sel = !model_sel;
            busy_left = MEM_DEPTH;
        end
        check_value(T_SET, 32'(model_sel), 32'(hist_sel));
        check_value(T_SET, 32'(busy_left != 0), 32'(busy));
    endtask

    task automatic apply_hit(input logic h, input bin_t b);
        mem_addr_t addr;
        count_t    old_cnt;
        count_t    new_cnt;
        hit = h;
        bin = b;
        pipe[0] = '0;
        pipe[0].drop = h && (busy_left != 0 || pipe[1].done);  // sweep running or launching
        if (h && !pipe[0].drop) begin
            addr    = mem_addr_t'(pix_idx * BIN_NUM + int'(b));
            old_cnt = model_mem[addr];
            if (int'(old_cnt) < COUNT_MAX) begin
                new_cnt = count_t'(int'(old_cnt) + 1);
            end else begin
                new_cnt = count_t'(COUNT_MAX);            // counts stop at the ceiling
            end
            model_mem[addr] = new_cnt;
            pipe[0].cv    = 1'b1;
            pipe[0].cnt   = new_cnt;
            pipe[0].fresh = (sets_done > 0) && (old_cnt == '0);
            if (new_cnt > best_cnt) begin                 // ties keep the earlier bin
                best_cnt = new_cnt;
                best_bin = b;
            end
            accepted++;
            hit_idx++;
            if (hit_idx == HITS_PER_PIXEL) begin
                pipe[0].pv   = 1'b1;
                pipe[0].ppix = pixel_t'(pix_idx);
                pipe[0].pbin = best_bin;
                pipe[0].pcnt = best_cnt;
                best_cnt = '0;
                hit_idx  = 0;
                pix_idx++;
            end
            if (pix_idx == PIXEL_NUM) begin
                pix_idx = 0;
                acq_idx++;
            end
            if (acq_idx == ACQ_NUM) begin
                acq_idx = 0;
                sets_done++;
                pipe[0].done = 1'b1;
                foreach (model_mem[a]) model_mem[a] = '0;  // whole histogram swept
            end
        end
    endtask

    task automatic run_cycle(input logic allow_hit);
        logic h;
        @(negedge clk);
        for (int k = 3; k > 0; k--) begin
            pipe[k] = pipe[k-1];
        end
        check_outputs();
        rnd = next_rand(rnd);
        h   = allow_hit && (rnd[0] || gap == MAX_GAP);
        gap = h ? 0 : gap + 1;
        apply_hit(h, rnd[3] ? rnd[11:8] : {2'b00, rnd[9:8]});  // narrow bins give repeats
        if (busy_left > 0) begin
            busy_left--;
        end
    endtask

    task automatic report_test(input int t);
        $display("test %-15s %0d checks, %0d errors", names[t], checks[t], errors[t]);
    endtask

    initial begin
        int total_checks;
        int total_errors;
        combin_res = 1'b0;
        hit        = 1'b0;
        bin        = '0;
        foreach (pipe[k]) pipe[k] = '0;
        foreach (model_mem[a]) model_mem[a] = '0;
        foreach (checks[t]) begin
            checks[t] = 0;
            errors[t] = 0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        combin_res = 1'b1;
        @(negedge clk);
        check_value(T_RESET, 32'd0, 32'(count_valid));
        check_value(T_RESET, 32'd0, 32'(peak_valid));
        check_value(T_RESET, 32'd0, 32'(acq_done));
        check_value(T_RESET, 32'd0, 32'(busy));
        check_value(T_RESET, 32'd0, 32'(hist_sel));
        report_test(T_RESET);

        while (accepted < NUM_SETS * SET_HITS) begin
            run_cycle(1'b1);
        end
        repeat (MEM_DEPTH + 4) run_cycle(1'b0);           // drain pipes and the last sweep

        total_checks = 0;
        total_errors = 0;
        for (int t = T_RESET; t <= T_CLEAR; t++) begin
            if (t != T_RESET) begin
                report_test(t);
            end
            total_checks += checks[t];
            total_errors += errors[t];
        end
        $display("summary: %0d sets, %0d checks, %0d errors", sets_done, total_checks,
                 total_errors);
        if (total_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG);
        $display("watchdog: run did not finish within %0d time units", WATCHDOG);
        $display("Test failures found");
        $finish;
    end

endmodule

/* src.f */
hdl/hist_pkg.sv
hdl/bin_access_if.sv
hdl/bin_update_if.sv
hdl/acq_sequencer.sv
hdl/bin_memory.sv
hdl/peak_tracker.sv
hdl/hist_top.sv
tests/tb_clock.sv
tests/hist_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= hist_tb
FILELIST   ?= src.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
PASS_MSG   ?= All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
